/* include/qbus_macros.svh */
/*
 * qbus bus-cycle unit parameters
 * bus widths, reply timeout and slave address window
 */
`ifndef QBUS_MACROS_SVH
`define QBUS_MACROS_SVH

// multiplexed AD bus
`define QBUS_AW            16    // address width
`define QBUS_DW            16    // data width

// cycles from DIN/DOUT until a missing RPLY counts as bus error
`define QBUS_RPLY_TIMEOUT  32

// words answered by the slave model, from address 0
`define QBUS_MEM_WORDS     256

`endif

/* source/qbus_pkg.sv */
/*
 * qbus bus-cycle unit types
 * operation enum, host command, decoded operation and result structs
 */
`include "qbus_macros.svh"

package qbus_pkg;

   // bus cycle kinds issued by the host
   typedef enum logic [1:0] {
      OP_DATI  = 2'd0,                    // word read
      OP_DATO  = 2'd1,                    // word write
      OP_DATOB = 2'd2,                    // byte write
      OP_IAKO  = 2'd3                     // interrupt vector acknowledge
   } qbus_op_e;

   // host command, 34 bits
   typedef struct packed {
      qbus_op_e               op;         // cycle kind
      logic [`QBUS_AW-1:0]    addr;       // byte address
      logic [`QBUS_DW-1:0]    wdata;      // write data, low byte for DATOB
   } qbus_cmd_t;

   // operation as seen by the cycle sequencer
   typedef struct packed {
      logic                   rd;         // DATI
      logic                   wr;         // DATO or DATOB
      logic                   byte_op;    // WTBT in data phase
      logic                   iak;        // IAKO cycle, no SYNC
      logic [`QBUS_AW-1:0]    addr;       // address phase word
      logic [`QBUS_DW-1:0]    wdata;      // lane-aligned write data
   } qbus_dec_t;

   // finished cycle, 19 bits
   typedef struct packed {
      logic [`QBUS_DW-1:0]    rdata;      // read data or vector, zero on error
      logic                   berr;       // no reply within timeout
      qbus_op_e               op;         // echo of the command kind
   } qbus_res_t;

endpackage

/* source/qbus_cmd_decode.sv */
/*
 * host command intake
 * four-phase req/ack receiver with a head slot and a reserve slot,
 * maps each command onto bus cycle flags
 */
`timescale 1ns/1ps

module qbus_cmd_decode
   import qbus_pkg::*;
(
   input  logic         pin_clk_p,     // bus clock, rising edge
   input  logic         rst,           // synchronous reset
   input  logic         cmd_req,       // host command request
   input  qbus_cmd_t    cmd,           // stable while cmd_req high
   output logic         cmd_ack,       // command latched
   input  logic         op_take,       // sequencer starts the head op
   output logic         op_valid,      // head slot occupied
   output qbus_dec_t    op             // head slot contents
);

qbus_dec_t  rsv_op;                    // reserve slot payload
logic       rsv_valid;                 // reserve slot occupied
logic       accept;                    // command latched this cycle

// turn a host command into strobe flags, byte data goes to its lane
function automatic qbus_dec_t decode(input qbus_cmd_t c);
   qbus_dec_t d;
   d.rd      = (c.op == OP_DATI);
   d.wr      = (c.op == OP_DATO) || (c.op == OP_DATOB);
   d.byte_op = (c.op == OP_DATOB);
   d.iak     = (c.op == OP_IAKO);
   d.addr    = c.addr;
   if (c.op == OP_DATOB)
      d.wdata = c.addr[0] ? {c.wdata[7:0], 8'h00} : {8'h00, c.wdata[7:0]};
   else
      d.wdata = c.wdata;
   return d;
endfunction

// new request, not yet acked, and at least one slot free
assign accept = cmd_req & ~cmd_ack & ~(op_valid & rsv_valid);

always_ff @(posedge pin_clk_p) begin
   if (rst) begin
      cmd_ack   <= 1'b0;
      op_valid  <= 1'b0;
      rsv_valid <= 1'b0;
   end else begin
      if (accept)
         cmd_ack <= 1'b1;              // ack one cycle after req
      else if (~cmd_req)
         cmd_ack <= 1'b0;              // req gone, close the handshake
      if (op_take & ~accept) begin
         op_valid  <= rsv_valid;       // reserve moves up, if any
         rsv_valid <= 1'b0;
      end else if (accept & ~op_take) begin
         if (op_valid)
            rsv_valid <= 1'b1;
         else
            op_valid  <= 1'b1;
      end
   end
end

// slot payloads, no reset needed
always_ff @(posedge pin_clk_p) begin
   if (op_take & accept)
      op <= decode(cmd);               // reserve empty here, refill head directly
   else if (op_take)
      op <= rsv_op;
   else if (accept & ~op_valid)
      op <= decode(cmd);
   if (accept & op_valid & ~op_take)
      rsv_op <= decode(cmd);
end

endmodule

/* source/qbus_cycle_exec.sv */
/*
 * qbus cycle sequencer
 * address, data, strobe, reply wait and release phases per operation,
 * reply timeout turns into a bus error
 */
`timescale 1ns/1ps
`include "qbus_macros.svh"

module qbus_cycle_exec
   import qbus_pkg::*;
(
   input  logic                  pin_clk_p,  // bus clock
   input  logic                  rst,        // synchronous reset
   input  logic                  op_valid,   // decoded op waiting
   input  qbus_dec_t             op,         // decoded op
   output logic                  op_take,    // start pulse
   input  logic                  res_busy,   // result stage still full
   output logic                  done,       // cycle finished pulse
   output qbus_res_t             done_res,   // valid with done
   input  logic [`QBUS_DW-1:0]   ad_in,      // true-sense AD bus
   input  logic                  rply,       // true-sense RPLY
   output logic [`QBUS_DW-1:0]   ad_out,     // AD value to drive
   output logic                  ad_ena,     // drive AD
   output logic                  ctrl_ena,   // drive SYNC/DIN/DOUT/WTBT
   output logic                  sync,
   output logic                  din,
   output logic                  dout,
   output logic                  wtbt,
   output logic                  iako
);

localparam int TMO_W = $clog2(`QBUS_RPLY_TIMEOUT + 1);

typedef enum logic [2:0] {
   S_IDLE,                             // bus released
   S_ADDR,                             // address on AD, no SYNC yet
   S_DATA,                             // SYNC up, data setup
   S_WAIT,                             // strobe up, waiting RPLY
   S_TERM,                             // strobe down, waiting RPLY low
   S_REL                               // SYNC down, lines still driven
} state_e;

state_e              state;
qbus_dec_t           cur;              // op in progress
logic [TMO_W-1:0]    tmo_cnt;          // cycles spent in S_WAIT
logic                tmo_hit;          // no reply in time
logic [`QBUS_DW-1:0] rdata_q;          // latched read data
logic                berr_q;           // latched bus error
qbus_op_e            op_echo;          // command kind rebuilt from flags

assign op_take = (state == S_IDLE) & op_valid & ~res_busy;
assign tmo_hit = (tmo_cnt == TMO_W'(`QBUS_RPLY_TIMEOUT - 1));

always_comb begin
   if (cur.iak)
      op_echo = OP_IAKO;
   else if (cur.rd)
      op_echo = OP_DATI;
   else if (cur.byte_op)
      op_echo = OP_DATOB;
   else
      op_echo = OP_DATO;
end

assign done_res = '{rdata: rdata_q, berr: berr_q, op: op_echo};

// pin levels follow the phase
always_comb begin
   ad_out   = '0;
   ad_ena   = 1'b0;
   ctrl_ena = (state != S_IDLE);       // own the control lines for the whole cycle
   sync     = 1'b0;
   din      = 1'b0;
   dout     = 1'b0;
   wtbt     = 1'b0;
   iako     = 1'b0;
   case (state)
      S_ADDR: begin
         ad_out = cur.addr;
         ad_ena = 1'b1;
         wtbt   = cur.wr;              // write indicated with the address
      end
      S_DATA, S_TERM: begin
         sync   = ~cur.iak;
         ad_out = cur.wdata;
         ad_ena = cur.wr;              // reads leave AD to the slave
         wtbt   = cur.byte_op;
      end
      S_WAIT: begin
         sync   = ~cur.iak;            // IAKO runs without SYNC
         ad_out = cur.wdata;
         ad_ena = cur.wr;
         wtbt   = cur.byte_op;
         din    = cur.rd | cur.iak;
         dout   = cur.wr;
         iako   = cur.iak;
      end
      default: ;
   endcase
end

always_ff @(posedge pin_clk_p) begin
   if (rst) begin
      state   <= S_IDLE;
      done    <= 1'b0;
      tmo_cnt <= '0;
   end else begin
      done <= 1'b0;
      case (state)
         S_IDLE: begin
            tmo_cnt <= '0;
            if (op_take)
               state <= op.iak ? S_WAIT : S_ADDR;  // vector read skips address
         end
         S_ADDR: state <= S_DATA;
         S_DATA: begin
            tmo_cnt <= '0;
            state   <= S_WAIT;
         end
         S_WAIT: begin
            if (rply | tmo_hit)
               state <= S_TERM;
            else
               tmo_cnt <= tmo_cnt + 1'b1;
         end
         S_TERM: if (~rply) state <= S_REL;        // slave finished its reply
         S_REL: begin
            state <= S_IDLE;
            done  <= 1'b1;
         end
         default: state <= S_IDLE;
      endcase
   end
end

// op and result payload
always_ff @(posedge pin_clk_p) begin
   if (op_take)
      cur <= op;
   if (state == S_WAIT) begin
      if (rply) begin
         rdata_q <= cur.wr ? '0 : ad_in;  // data or vector on reply
         berr_q  <= 1'b0;
      end else if (tmo_hit) begin
         rdata_q <= '0;
         berr_q  <= 1'b1;
      end
   end
end

endmodule

/* source/qbus_result.sv */
/*
 * result return stage
 * captures a finished cycle and hands it to the host over four-phase req/ack
 */
`timescale 1ns/1ps

module qbus_result
   import qbus_pkg::*;
(
   input  logic         pin_clk_p,     // bus clock
   input  logic         rst,           // synchronous reset
   input  logic         done,          // cycle finished pulse
   input  qbus_res_t    done_res,      // valid with done
   output logic         res_busy,      // hold off the sequencer
   output logic         res_req,       // result request to host
   output qbus_res_t    res,           // stable while res_req high
   input  logic         res_ack        // host took the result
);

logic busy_q;                          // result held until handshake closes

// done counts as busy too, the sequencer sees it the same cycle
assign res_busy = busy_q | done;

always_ff @(posedge pin_clk_p) begin
   if (rst) begin
      busy_q  <= 1'b0;
      res_req <= 1'b0;
   end else begin
      if (done) begin
         busy_q  <= 1'b1;
         res_req <= 1'b1;              // one cycle after done
      end else begin
         if (res_req & res_ack)
            res_req <= 1'b0;           // host has it, drop request
         if (busy_q & ~res_req & ~res_ack)
            busy_q  <= 1'b0;           // ack fell, handshake closed
      end
   end
end

// result payload
always_ff @(posedge pin_clk_p) begin
   if (done)
      res <= done_res;
end

endmodule

/* source/qbus_unit.sv */
/*
 * qbus bus-cycle unit top level
 * pin inversion, tri-state and open-drain drivers, decode/exec/result blocks
 */
`timescale 1ns/1ps
`include "qbus_macros.svh"

module qbus_unit
   import qbus_pkg::*;
(
   input  logic                  pin_clk_p,     // bus clock, rising edge
   input  logic                  rst,           // synchronous reset
   input  logic                  cmd_req,       // host command channel
   input  qbus_cmd_t             cmd,
   output logic                  cmd_ack,
   output logic                  res_req,       // host result channel
   output qbus_res_t             res,
   input  logic                  res_ack,
   inout  wire [`QBUS_DW-1:0]    pin_ad_n,      // inverted address/data bus
   input  logic                  pin_rply_n,    // transaction reply
   output wire                   pin_sync_n,    // address strobe
   output wire                   pin_din_n,     // data input strobe
   output wire                   pin_dout_n,    // data output strobe
   output wire                   pin_wtbt_n,    // write/byte status
   output wire                   pin_iako_n,    // interrupt vector input
   output wire                   pin_init_n     // peripheral reset, open drain
);

logic                op_valid;
qbus_dec_t           op;
logic                op_take;
logic                res_busy;
logic                done;
qbus_res_t           done_res;
logic [`QBUS_DW-1:0] ad_out;
logic                ad_ena;
logic                ctrl_ena;
logic                sync;
logic                din;
logic                dout;
logic                wtbt;
logic                iako;

// shared lines released when not driven
assign pin_ad_n   = ad_ena   ? ~ad_out : {`QBUS_DW{1'bz}};
assign pin_sync_n = ctrl_ena ? ~sync : 1'bz;
assign pin_din_n  = ctrl_ena ? ~din  : 1'bz;
assign pin_dout_n = ctrl_ena ? ~dout : 1'bz;
assign pin_wtbt_n = ctrl_ena ? ~wtbt : 1'bz;
assign pin_iako_n = ~iako;                    // always driven
assign pin_init_n = rst ? 1'b0 : 1'bz;        // pulled low during reset only

qbus_cmd_decode decode_i (
   .pin_clk_p  (pin_clk_p),
   .rst        (rst),
   .cmd_req    (cmd_req),
   .cmd        (cmd),
   .cmd_ack    (cmd_ack),
   .op_take    (op_take),
   .op_valid   (op_valid),
   .op         (op)
);

qbus_cycle_exec exec_i (
   .pin_clk_p  (pin_clk_p),
   .rst        (rst),
   .op_valid   (op_valid),
   .op         (op),
   .op_take    (op_take),
   .res_busy   (res_busy),
   .done       (done),
   .done_res   (done_res),
   .ad_in      (~pin_ad_n),
   .rply       (~pin_rply_n),
   .ad_out     (ad_out),
   .ad_ena     (ad_ena),
   .ctrl_ena   (ctrl_ena),
   .sync       (sync),
   .din        (din),
   .dout       (dout),
   .wtbt       (wtbt),
   .iako       (iako)
);

qbus_result result_i (
   .pin_clk_p  (pin_clk_p),
   .rst        (rst),
   .done       (done),
   .done_res   (done_res),
   .res_busy   (res_busy),
   .res_req    (res_req),
   .res        (res),
   .res_ack    (res_ack)
);

endmodule

/* tb/qbus_unit_asserts.sv */
/*
 * Qbus strobe protocol assertions for the cycle sequencer,
 * bound into qbus_cycle_exec
 */
`timescale 1ns/1ps

module qbus_unit_asserts (
   input logic pin_clk_p,
   input logic rst,
   input logic sync,
   input logic din,
   input logic dout,
   input logic iako
);

// one data strobe at a time
a_one_strobe: assert property (@(posedge pin_clk_p) disable iff (rst) !(din && dout))
   else $error("din and dout asserted together");

// DATI/DATO strobes sit inside SYNC
a_sync_frame: assert property (@(posedge pin_clk_p) disable iff (rst)
   (dout || (din && !iako)) |-> sync)
   else $error("data strobe without sync");

// vector read runs without SYNC
a_iako_nosync: assert property (@(posedge pin_clk_p) disable iff (rst) !(iako && sync))
   else $error("iako together with sync");

endmodule

bind qbus_cycle_exec qbus_unit_asserts asserts_i (
   .pin_clk_p (pin_clk_p),
   .rst       (rst),
   .sync      (sync),
   .din       (din),
   .dout      (dout),
   .iako      (iako)
);

/* tb/qbus_unit_tb.sv */
/*
 * qbus unit testbench: clock, reset, Qbus slave memory model,
 * host command/result tasks, directed tests, cycle limit and final report
 */
`timescale 1ns/1ps
`include "qbus_macros.svh"

module qbus_unit_tb
   import qbus_pkg::*;
();

localparam logic [15:0] IAK_VECTOR = 16'o000270;          // vector returned on IAKO
localparam int MAX_CYCLES = 20 * (2 * `QBUS_RPLY_TIMEOUT + 40);

logic        pin_clk_p;
logic        rst;
logic        cmd_req;
qbus_cmd_t   cmd;
logic        cmd_ack;
logic        res_req;
qbus_res_t   res;
logic        res_ack;
tri1 [15:0]  pin_ad_n;                 // pulled up, released bus reads as zero
tri1         pin_rply_n;
tri1         pin_sync_n;
tri1         pin_din_n;
tri1         pin_dout_n;
tri1         pin_wtbt_n;
tri1         pin_init_n;
wire         pin_iako_n;

integer      seed = 32'hbf46;
int          errors = 0;
int          checks = 0;
int          cycles = 0;
logic [15:0] mem [0:`QBUS_MEM_WORDS-1];        // slave contents
logic [15:0] exp_mem [0:`QBUS_MEM_WORDS-1];    // expected contents
logic [15:0] addr_lat = '0;            // address seen before SYNC
logic [15:0] slv_ad = '0;
logic        slv_ad_ena = 1'b0;
logic        slv_rply = 1'b0;
logic        strobe_seen = 1'b0;
int          dly = 0;                  // cycles left until RPLY
logic        iak_sync_seen = 1'b0;

assign pin_ad_n   = slv_ad_ena ? ~slv_ad : 16'hzzzz;
assign pin_rply_n = slv_rply ? 1'b0 : 1'bz;

qbus_unit dut_i (.*);

initial begin
   pin_clk_p = 1'b0;
   forever #5 pin_clk_p = ~pin_clk_p;
end

// run limit
always @(posedge pin_clk_p) begin
   cycles <= cycles + 1;
   if (cycles >= MAX_CYCLES) begin
      $display("timeout: no progress within %0d cycles", MAX_CYCLES);
      $display("checks: %0d errors: %0d", checks, errors);
      $display("test failed");
      $finish;
   end
end

function automatic logic [15:0] fill_word(input int unsigned w);
   return {w[7:0], ~w[7:0]} ^ 16'h0f0f;               // both bytes follow the index
endfunction

// slave reply once the delay runs out, silent outside the window
task automatic slave_reply();
   int unsigned w;
   w = addr_lat[15:1];
   if (pin_iako_n === 1'b0) begin
      slv_ad     <= IAK_VECTOR;
      slv_ad_ena <= 1'b1;
      slv_rply   <= 1'b1;
   end else if (w < `QBUS_MEM_WORDS) begin
      if (pin_din_n === 1'b0) begin
         slv_ad     <= mem[w];
         slv_ad_ena <= 1'b1;
      end else if (pin_wtbt_n !== 1'b0)
         mem[w] = ~pin_ad_n;                           // word write
      else if (addr_lat[0])
         mem[w][15:8] = ~pin_ad_n[15:8];               // odd byte, high lane
      else
         mem[w][7:0] = ~pin_ad_n[7:0];
      slv_rply <= 1'b1;
   end
endtask

always @(posedge pin_clk_p) begin
   if (pin_sync_n !== 1'b0)
      addr_lat = ~pin_ad_n;                            // last word before SYNC
   if (pin_iako_n === 1'b0 && pin_sync_n === 1'b0)
      iak_sync_seen = 1'b1;
   if (pin_din_n !== 1'b0 && pin_dout_n !== 1'b0) begin
      strobe_seen = 1'b0;                              // strobe gone, let go
      slv_rply   <= 1'b0;
      slv_ad_ena <= 1'b0;
   end else if (!strobe_seen) begin
      strobe_seen = 1'b1;
      dly = 1 + ({$random(seed)} % 3);                 // 1 to 3 cycles
   end
   if (strobe_seen && dly > 0) begin
      dly = dly - 1;
      if (dly == 0)
         slave_reply();
   end
end

task automatic compare(input string name, input logic [15:0] got, input logic [15:0] exp);
   checks++;
   assert (got === exp) else begin
      errors++;
      $display("Mismatch %s: got %h expected %h", name, got, exp);
   end
endtask

// expected result per cycle rules, updates the expected memory in command order
function automatic qbus_res_t predict(input qbus_op_e op, input logic [15:0] addr,
                                     input logic [15:0] wdata);
   qbus_res_t   e;
   int unsigned w;
   w = addr[15:1];
   e = '{rdata: 16'h0000, berr: 1'b0, op: op};
   if (op == OP_IAKO)
      e.rdata = IAK_VECTOR;
   else if (w >= `QBUS_MEM_WORDS)
      e.berr = 1'b1;                                   // nobody answers
   else if (op == OP_DATI)
      e.rdata = exp_mem[w];
   else if (op == OP_DATO)
      exp_mem[w] = wdata;
   else if (addr[0])
      exp_mem[w][15:8] = wdata[7:0];
   else
      exp_mem[w][7:0] = wdata[7:0];
   return e;
endfunction

task automatic send_cmd(input qbus_op_e op, input logic [15:0] addr, input logic [15:0] wdata);
   @(posedge pin_clk_p);
   cmd_req <= 1'b1;
   cmd     <= '{op: op, addr: addr, wdata: wdata};
   do @(posedge pin_clk_p); while (cmd_ack !== 1'b1);
   cmd_req <= 1'b0;
   do @(posedge pin_clk_p); while (cmd_ack !== 1'b0);
endtask

task automatic get_res(input int ack_dly, output qbus_res_t r);
   do @(posedge pin_clk_p); while (res_req !== 1'b1);
   r = res;
   repeat (ack_dly) @(posedge pin_clk_p);              // slow host
   res_ack <= 1'b1;
   do @(posedge pin_clk_p); while (res_req !== 1'b0);
   res_ack <= 1'b0;
endtask

task automatic check_res(input qbus_res_t got, input qbus_res_t exp);
   compare("res.op", got.op, exp.op);
   compare("res.berr", got.berr, exp.berr);
   if (exp.berr || exp.op == OP_DATI || exp.op == OP_IAKO)
      compare("res.rdata", got.rdata, exp.rdata);
endtask

task automatic run_op(input qbus_op_e op, input logic [15:0] addr, input logic [15:0] wdata,
                      input int ack_dly);
   qbus_res_t e;
   qbus_res_t r;
   e = predict(op, addr, wdata);
   send_cmd(op, addr, wdata);
   get_res(ack_dly, r);
   check_res(r, e);
endtask

task automatic test_reset();
   @(posedge pin_clk_p);
   compare("pin_init_n", pin_init_n, 1'b0);            // INIT pulled low in reset
   repeat (2) @(posedge pin_clk_p);
   rst <= 1'b0;
   repeat (2) @(posedge pin_clk_p);
   compare("pin_sync_n", pin_sync_n, 1'b1);
   compare("pin_din_n", pin_din_n, 1'b1);
   compare("pin_dout_n", pin_dout_n, 1'b1);
   compare("pin_iako_n", pin_iako_n, 1'b1);
   compare("pin_init_n", pin_init_n, 1'b1);
   compare("cmd_ack", cmd_ack, 1'b0);
   compare("res_req", res_req, 1'b0);
endtask

task automatic test_word_rw();
   run_op(OP_DATO, 16'o000100, 16'h1234, 0);
   run_op(OP_DATI, 16'o000100, 16'h0000, 0);
   run_op(OP_DATO, 16'o000776, 16'hfedc, 3);           // top word of the window
   run_op(OP_DATI, 16'o000776, 16'h0000, 3);
endtask

task automatic test_byte_lanes();
   run_op(OP_DATO, 16'h0040, 16'hdead, 0);
   run_op(OP_DATOB, 16'h0040, 16'h005a, 0);            // low lane
   run_op(OP_DATI, 16'h0040, 16'h0000, 0);
   run_op(OP_DATOB, 16'h0041, 16'hffc3, 0);            // high lane, upper bits unused
   run_op(OP_DATI, 16'h0040, 16'h0000, 0);
   run_op(OP_DATI, 16'h0042, 16'h0000, 0);             // neighbour untouched
endtask

task automatic test_iako();
   iak_sync_seen = 1'b0;
   run_op(OP_IAKO, 16'h0000, 16'h0000, 0);
   checks++;
   assert (!iak_sync_seen) else begin
      errors++;
      $display("SYNC was asserted during the interrupt acknowledge cycle");
   end
endtask

task automatic test_bus_error();
   run_op(OP_DATI, 16'h8000, 16'h0000, 0);
   run_op(OP_DATO, 16'h0200, 16'h5555, 0);             // first word past the window
   run_op(OP_DATI, 16'h0100, 16'h0000, 0);
endtask

// writes and read-backs in flight while results are drained with stalls
task automatic test_random_traffic();
   qbus_res_t   exp_q[$];
   qbus_res_t   got;
   logic [15:0] addr;
   logic [15:0] data;
   fork
      begin
         for (int i = 0; i < 16; i++) begin
            addr = 16'(({$random(seed)} % `QBUS_MEM_WORDS) * 2);
            data = $random(seed);
            exp_q.push_back(predict(OP_DATO, addr, data));
            send_cmd(OP_DATO, addr, data);
            exp_q.push_back(predict(OP_DATI, addr, 16'h0000));
            send_cmd(OP_DATI, addr, 16'h0000);
         end
      end
      begin
         for (int j = 0; j < 32; j++) begin
            get_res((j % 4 == 3) ? 7 : 0, got);
            assert (exp_q.size() > 0) else begin
               errors++;
               $display("result returned with no command outstanding");
            end
            if (exp_q.size() > 0)
               check_res(got, exp_q.pop_front());
         end
      end
   join
   assert (exp_q.size() == 0) else begin
      errors++;
      $display("%0d commands finished without a result", exp_q.size());
   end
endtask

initial begin
   rst     = 1'b1;
   cmd_req = 1'b0;
   cmd     = '0;
   res_ack = 1'b0;
   for (int i = 0; i < `QBUS_MEM_WORDS; i++) begin
      mem[i]     = fill_word(i);
      exp_mem[i] = fill_word(i);
   end
   test_reset();
   test_word_rw();
   test_byte_lanes();
   test_iako();
   test_bus_error();
   test_random_traffic();
   repeat (4) @(posedge pin_clk_p);
   $display("checks: %0d errors: %0d", checks, errors);
   if (errors == 0)
      $display("test passed");
   else
      $display("test failed");
   $finish;
end

endmodule

/* build.f */
+incdir+include
source/qbus_pkg.sv
source/qbus_cmd_decode.sv
source/qbus_cycle_exec.sv
source/qbus_result.sv
source/qbus_unit.sv
tb/qbus_unit_asserts.sv
tb/qbus_unit_tb.sv

/* Bender.yml */
package:
  name: qbus_unit

export_include_dirs:
  - include

sources:
  - files:
      - source/qbus_pkg.sv
      - source/qbus_cmd_decode.sv
      - source/qbus_cycle_exec.sv
      - source/qbus_result.sv
      - source/qbus_unit.sv
  - target: test
    files:
      - tb/qbus_unit_asserts.sv
      - tb/qbus_unit_tb.sv
